//--- axi_sram_top.f
src/axi_sram_pkg.sv
src/axi_write_front.sv
src/axi_sram_ctrl.sv
src/sram_array.sv
src/axi_read_back.sv
src/axi_sram_top.sv
testbench/tb_clock.sv
testbench/axi_sram_tb.sv

//--- src/axi_read_back.sv
`timescale 1ns/1ns

module axi_read_back (
    input  logic                                   clk, rst,
    input  logic                                   push_i,
    input  logic [axi_sram_pkg::axi_data_bits-1:0] rdata_i,
    input  logic                                   last_i,
    input  logic [axi_sram_pkg::axi_id_bits-1:0]   id_i,
    input  logic                                   rready_i,
    output logic                                   rvalid_o,
    output logic [axi_sram_pkg::axi_data_bits-1:0] rdata_o,
    output logic                                   rlast_o,
    output logic [axi_sram_pkg::axi_id_bits-1:0]   rid_o,
    output logic [1:0]                             rresp_o,
    output logic [1:0]                             buf_free_o,
    output logic                                   beat_taken_o
);

    import axi_sram_pkg::*;

    logic                     push_q;
    logic                     last_s;
    logic [axi_id_bits-1:0]   id_s;
    logic [axi_data_bits-1:0] data_mem [2];
    logic                     last_mem [2];
    logic [axi_id_bits-1:0]   id_mem   [2];
    logic                     wr_ptr_q;
    logic                     rd_ptr_q;
    logic [1:0]               count_q;
    logic                     pop;

    assign rvalid_o     = count_q != 2'd0;
    assign pop          = rvalid_o & rready_i;
    assign beat_taken_o = pop;
    assign buf_free_o   = 2'd2 - count_q;
    assign rdata_o      = data_mem[rd_ptr_q];
    assign rlast_o      = last_mem[rd_ptr_q];
    assign rid_o        = id_mem[rd_ptr_q];
    assign rresp_o      = resp_okay;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            push_q   <= 1'b0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            // SRAM data shows up the cycle after the read strobe
            push_q <= push_i;
            if (push_q) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push_q} - {1'b0, pop};
        end
    end

    // last and id wait one cycle to line up with the data
    always_ff @(posedge clk) begin
        if (push_i) begin
            last_s <= last_i;
            id_s   <= id_i;
        end
        if (push_q) begin
            data_mem[wr_ptr_q] <= rdata_i;
            last_mem[wr_ptr_q] <= last_s;
            id_mem[wr_ptr_q]   <= id_s;
        end
    end

    // read credit in the controller keeps this from overflowing
    assert property (@(posedge clk) disable iff (!rst)
        push_q |-> count_q != 2'd2);

endmodule

//--- src/axi_sram_ctrl.sv
`timescale 1ns/1ns

module axi_sram_ctrl #(
    parameter int sram_a_bits = 10
) (
    input  logic                                  clk, rst,
    input  logic [axi_sram_pkg::axi_id_bits-1:0]  awid_i,
    input  logic                                  awvalid_i,
    input  logic [axi_sram_pkg::axi_id_bits-1:0]  arid_i,
    input  axi_sram_pkg::byte_addr_u              araddr_i,
    input  logic [axi_sram_pkg::axi_len_bits-1:0] arlen_i,
    input  logic                                  arvalid_i,
    input  logic                                  bready_i,
    input  logic                                  wr_done_i,
    input  logic [1:0]                            buf_free_i,
    input  logic                                  rd_beat_taken_i,
    output logic                                  awready_o,
    output logic                                  arready_o,
    output logic                                  wr_start_o,
    output logic                                  rd_en_o,
    output logic [sram_a_bits-1:0]                rd_addr_o,
    output logic                                  rd_last_o,
    output logic [axi_sram_pkg::axi_id_bits-1:0]  id_o,
    output logic                                  bvalid_o,
    output logic [axi_sram_pkg::axi_id_bits-1:0]  bid_o,
    output logic [1:0]                            bresp_o
);

    import axi_sram_pkg::*;

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_read  = 2'd1;
    localparam logic [1:0] st_write = 2'd2;
    localparam logic [1:0] st_resp  = 2'd3;

    logic [1:0]              state_q;
    logic [1:0]              state_d;
    logic                    idle_q;
    logic                    issuing_q;
    logic                    in_flight_q;
    logic [axi_len_bits-1:0] iss_cnt_q;
    logic [axi_len_bits-1:0] tk_cnt_q;
    logic [axi_len_bits-1:0] len_q;
    logic [axi_id_bits-1:0]  id_q;
    logic [sram_a_bits-1:0]  rd_addr_q;
    logic                    awhs;
    logic                    arhs;
    logic                    credit;
    logic                    rd_done;

    // write wins when both arrive in the same idle cycle
    assign awready_o  = idle_q;
    assign arready_o  = idle_q & ~awvalid_i & (buf_free_i == 2'd2);
    assign awhs       = awvalid_i & awready_o;
    assign arhs       = arvalid_i & arready_o;
    assign wr_start_o = awhs;

    // free slot left after the read still coming out of the SRAM
    assign credit    = ({1'b0, buf_free_i} + {2'b00, rd_beat_taken_i}) > {2'b00, in_flight_q};
    assign rd_en_o   = issuing_q & credit;
    assign rd_last_o = iss_cnt_q == len_q;
    assign rd_addr_o = rd_addr_q;
    assign rd_done   = rd_beat_taken_i & (tk_cnt_q == len_q);

    assign id_o     = id_q;
    assign bid_o    = id_q;
    assign bvalid_o = state_q == st_resp;
    assign bresp_o  = resp_okay;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (awhs) begin
                    state_d = st_write;
                end else if (arhs) begin
                    state_d = st_read;
                end
            end
            st_read: begin
                if (rd_done) begin
                    state_d = st_idle;
                end
            end
            st_write: begin
                if (wr_done_i) begin
                    state_d = st_resp;
                end
            end
            st_resp: begin
                if (bready_i) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= st_idle;
            idle_q      <= 1'b0;
            issuing_q   <= 1'b0;
            in_flight_q <= 1'b0;
            iss_cnt_q   <= '0;
            tk_cnt_q    <= '0;
        end else begin
            state_q     <= state_d;
            idle_q      <= state_d == st_idle;
            in_flight_q <= rd_en_o;
            if (arhs) begin
                issuing_q <= 1'b1;
                iss_cnt_q <= '0;
                tk_cnt_q  <= '0;
            end else begin
                if (rd_en_o) begin
                    issuing_q <= ~rd_last_o;
                    iss_cnt_q <= iss_cnt_q + 1'b1;
                end
                if (rd_beat_taken_i) begin
                    tk_cnt_q <= tk_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awhs) begin
            id_q <= awid_i;
        end else if (arhs) begin
            id_q      <= arid_i;
            len_q     <= arlen_i;
            rd_addr_q <= araddr_i.fields.word[sram_a_bits-1:0];
        end else if (rd_en_o) begin
            rd_addr_q <= rd_addr_q + 1'b1;
        end
    end

    // the wlast beat of the write side only comes while a write is open
    assert property (@(posedge clk) disable iff (!rst)
        wr_done_i |-> state_q == st_write);

endmodule

//--- src/axi_sram_pkg.sv
package axi_sram_pkg;

    localparam int axi_data_bits = 32;
    localparam int axi_strb_bits = 4;
    localparam int axi_id_bits   = 4;
    // N means N+1 beats
    localparam int axi_len_bits  = 4;
    localparam int axi_addr_bits = 32;

    // widest word index the address split can carry
    localparam int word_idx_bits = 16;

    localparam logic [1:0] resp_okay  = 2'b00;
    localparam logic [1:0] burst_incr = 2'b01;

    // same byte address seen flat or as word index plus byte lane
    typedef union packed {
        logic [axi_addr_bits-1:0] raw;
        struct packed {
            logic [axi_addr_bits-word_idx_bits-3:0] upper;
            logic [word_idx_bits-1:0]               word;
            logic [1:0]                             offset;
        } fields;
    } byte_addr_u;

endpackage

//--- src/axi_sram_top.sv
`timescale 1ns/1ns

module axi_sram_top #(
    parameter int sram_a_bits = 10
) (
    input  logic                                   clk, rst,
    input  logic [axi_sram_pkg::axi_id_bits-1:0]   awid_i,
    input  axi_sram_pkg::byte_addr_u               awaddr_i,
    input  logic [axi_sram_pkg::axi_len_bits-1:0]  awlen_i,
    input  logic [1:0]                             awburst_i,
    input  logic                                   awvalid_i,
    output logic                                   awready_o,
    input  logic [axi_sram_pkg::axi_data_bits-1:0] wdata_i,
    input  logic [axi_sram_pkg::axi_strb_bits-1:0] wstrb_i,
    input  logic                                   wlast_i,
    input  logic                                   wvalid_i,
    output logic                                   wready_o,
    output logic [axi_sram_pkg::axi_id_bits-1:0]   bid_o,
    output logic [1:0]                             bresp_o,
    output logic                                   bvalid_o,
    input  logic                                   bready_i,
    input  logic [axi_sram_pkg::axi_id_bits-1:0]   arid_i,
    input  axi_sram_pkg::byte_addr_u               araddr_i,
    input  logic [axi_sram_pkg::axi_len_bits-1:0]  arlen_i,
    input  logic [1:0]                             arburst_i,
    input  logic                                   arvalid_i,
    output logic                                   arready_o,
    output logic [axi_sram_pkg::axi_id_bits-1:0]   rid_o,
    output logic [axi_sram_pkg::axi_data_bits-1:0] rdata_o,
    output logic [1:0]                             rresp_o,
    output logic                                   rlast_o,
    output logic                                   rvalid_o,
    input  logic                                   rready_i
);

    import axi_sram_pkg::*;

    logic                     wr_start;
    logic                     wr_en;
    logic [sram_a_bits-1:0]   wr_addr;
    logic [axi_data_bits-1:0] wr_data;
    logic [axi_strb_bits-1:0] wr_be;
    logic                     wr_done;
    logic                     rd_en;
    logic [sram_a_bits-1:0]   rd_addr;
    logic                     rd_last;
    logic [axi_id_bits-1:0]   id;
    logic [1:0]               buf_free;
    logic                     beat_taken;
    logic [sram_a_bits-1:0]   sram_addr;
    logic [axi_data_bits-1:0] sram_rdata;

    // write beats own the port whenever they come
    assign sram_addr = wr_en ? wr_addr : rd_addr;

    axi_write_front #(.sram_a_bits(sram_a_bits)) i_axi_write_front (
        .clk(clk), .rst(rst),
        .awaddr_i(awaddr_i), .awlen_i(awlen_i),
        .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wlast_i(wlast_i),
        .wr_start_i(wr_start), .wready_o(wready_o),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .wr_be_o(wr_be),
        .wr_done_o(wr_done)
    );

    axi_sram_ctrl #(.sram_a_bits(sram_a_bits)) i_axi_sram_ctrl (
        .clk(clk), .rst(rst),
        .awid_i(awid_i), .awvalid_i(awvalid_i),
        .arid_i(arid_i), .araddr_i(araddr_i), .arlen_i(arlen_i), .arvalid_i(arvalid_i),
        .bready_i(bready_i), .wr_done_i(wr_done),
        .buf_free_i(buf_free), .rd_beat_taken_i(beat_taken),
        .awready_o(awready_o), .arready_o(arready_o), .wr_start_o(wr_start),
        .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_last_o(rd_last), .id_o(id),
        .bvalid_o(bvalid_o), .bid_o(bid_o), .bresp_o(bresp_o)
    );

    sram_array #(.sram_a_bits(sram_a_bits)) i_sram_array (
        .clk(clk),
        .wr_en_i(wr_en), .wr_be_i(wr_be), .wr_data_i(wr_data),
        .rd_en_i(rd_en), .addr_i(sram_addr), .rdata_o(sram_rdata)
    );

    axi_read_back i_axi_read_back (
        .clk(clk), .rst(rst),
        .push_i(rd_en), .rdata_i(sram_rdata), .last_i(rd_last), .id_i(id),
        .rready_i(rready_i),
        .rvalid_o(rvalid_o), .rdata_o(rdata_o), .rlast_o(rlast_o), .rid_o(rid_o),
        .rresp_o(rresp_o), .buf_free_o(buf_free), .beat_taken_o(beat_taken)
    );

    // fixed and wrap run as incr, only the reserved code is illegal
    assert property (@(posedge clk) disable iff (!rst)
        awvalid_i && awready_o |-> awburst_i != 2'b11);
    assert property (@(posedge clk) disable iff (!rst)
        arvalid_i && arready_o |-> arburst_i != 2'b11);

endmodule

//--- src/axi_write_front.sv
`timescale 1ns/1ns

module axi_write_front #(
    parameter int sram_a_bits = 10
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  axi_sram_pkg::byte_addr_u               awaddr_i,
    input  logic [axi_sram_pkg::axi_len_bits-1:0]  awlen_i,
    input  logic [axi_sram_pkg::axi_data_bits-1:0] wdata_i,
    input  logic [axi_sram_pkg::axi_strb_bits-1:0] wstrb_i,
    input  logic                                   wvalid_i,
    input  logic                                   wlast_i,
    input  logic                                   wr_start_i,
    output logic                                   wready_o,
    output logic                                   wr_en_o,
    output logic [sram_a_bits-1:0]                 wr_addr_o,
    output logic [axi_sram_pkg::axi_data_bits-1:0] wr_data_o,
    output logic [axi_sram_pkg::axi_strb_bits-1:0] wr_be_o,
    output logic                                   wr_done_o
);

    import axi_sram_pkg::*;

    logic                    active_q;
    logic [axi_len_bits-1:0] beat_q;
    logic [axi_len_bits-1:0] len_q;
    logic [sram_a_bits-1:0]  addr_q;
    logic                    whs;

    assign whs = wvalid_i & active_q;

    // W beats go straight to the SRAM port
    assign wready_o  = active_q;
    assign wr_en_o   = whs;
    assign wr_addr_o = addr_q;
    assign wr_data_o = wdata_i;
    assign wr_be_o   = wstrb_i;
    assign wr_done_o = whs & wlast_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            active_q <= 1'b0;
            beat_q   <= '0;
        end else if (wr_start_i) begin
            active_q <= 1'b1;
            beat_q   <= '0;
        end else if (whs) begin
            active_q <= ~wlast_i;
            beat_q   <= beat_q + 1'b1;
        end
    end

    // word index only, upper address bits wrap
    always_ff @(posedge clk) begin
        if (wr_start_i) begin
            addr_q <= awaddr_i.fields.word[sram_a_bits-1:0];
            len_q  <= awlen_i;
        end else if (whs) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // wlast from the master has to agree with awlen
    assert property (@(posedge clk) disable iff (!rst)
        whs |-> (wlast_i == (beat_q == len_q)));

endmodule

//--- src/sram_array.sv
`timescale 1ns/1ns

module sram_array #(
    parameter int sram_a_bits = 10
) (
    input  logic                                   clk,
    input  logic                                   wr_en_i,
    input  logic [axi_sram_pkg::axi_strb_bits-1:0] wr_be_i,
    input  logic [axi_sram_pkg::axi_data_bits-1:0] wr_data_i,
    input  logic                                   rd_en_i,
    input  logic [sram_a_bits-1:0]                 addr_i,
    output logic [axi_sram_pkg::axi_data_bits-1:0] rdata_o
);

    import axi_sram_pkg::*;

    localparam int depth = 2 ** sram_a_bits;

    logic [axi_data_bits-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            // byte lanes under their own enables
            for (int b = 0; b < axi_strb_bits; b++) begin
                if (wr_be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
        if (rd_en_i) begin
            rdata_o <= mem[addr_i];
        end
    end

    // single port, write and read sides must never collide
    assert property (@(posedge clk) !(wr_en_i && rd_en_i));

endmodule

//--- testbench/axi_sram_tb.sv
`timescale 1ns/1ns

module axi_sram_tb;

    import axi_sram_pkg::*;

    localparam int a_bits   = 10;
    localparam int depth    = 2 ** a_bits;
    localparam int max_wait = 200;
    // bit positions in fire
    localparam int ch_aw = 0, ch_w = 1, ch_b = 2, ch_ar = 3, ch_r = 4;

    logic                     clk, rst;
    logic [axi_id_bits-1:0]   awid, arid, bid, rid;
    byte_addr_u               awaddr, araddr;
    logic [axi_len_bits-1:0]  awlen, arlen;
    logic [1:0]               awburst, arburst, bresp, rresp;
    logic [axi_data_bits-1:0] wdata, rdata;
    logic [axi_strb_bits-1:0] wstrb;
    logic                     awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic                     arvalid, arready, rvalid, rready, rlast;
    logic [4:0]               fire;
    logic [axi_data_bits-1:0] model [depth];
    integer                   seed;
    logic                     stall_on;
    string                    test_name;
    int                       ar_accepts = 0;

    assign fire = {rvalid & rready, arready, bvalid, wready, awready};

    tb_clock #(.period_ns(100)) i_tb_clock (.clk_o(clk));

    axi_sram_top #(.sram_a_bits(a_bits)) i_axi_sram_top (
        .clk(clk), .rst(rst),
        .awid_i(awid), .awaddr_i(awaddr), .awlen_i(awlen), .awburst_i(awburst),
        .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast), .wvalid_i(wvalid),
        .wready_o(wready),
        .bid_o(bid), .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
        .arid_i(arid), .araddr_i(araddr), .arlen_i(arlen), .arburst_i(arburst),
        .arvalid_i(arvalid), .arready_o(arready),
        .rid_o(rid), .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast),
        .rvalid_o(rvalid), .rready_i(rready)
    );

    // AR handshakes, counted where the inputs are settled
    always @(negedge clk) begin
        if (arvalid && arready) begin
            ar_accepts++;
        end
    end

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_rdata(input string what, input logic [axi_data_bits-1:0] exp, act);
        if (act !== exp) begin
            $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] exp, act);
        if (act !== exp) begin
            $display("mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_id(input string what, input logic [axi_id_bits-1:0] exp, act);
        if (act !== exp) begin
            $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_last(input string what, input logic exp, act);
        if (act !== exp) begin
            $display("mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic to_drive_point();
        @(posedge clk);
        #10;
    endtask

    // handshake seen at the falling edge lands on the next rising edge
    task automatic wait_for(input int ch, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!fire[ch]) begin
            n++;
            if (n >= max_wait) begin
                $display("timeout in %s while waiting for %s", test_name, what);
                stop_with_failure();
            end
            to_drive_point();
            rready = stall_on ? 1'($random(seed)) : 1'b1;
            @(negedge clk);
        end
    endtask

    // bits above the word index drop out, so the index wraps at the depth
    function automatic int word_index(input logic [axi_addr_bits-1:0] addr, input int beat);
        return int'(((addr >> 2) + beat) % depth);
    endfunction

    function automatic logic [axi_addr_bits-1:0] low_addr();
        logic [axi_addr_bits-1:0] a;
        a = $random(seed);
        return (a % (depth * 4)) & ~32'd3;
    endfunction

    task automatic write_burst(input logic [axi_addr_bits-1:0] addr,
                               input logic [axi_len_bits-1:0] len,
                               input logic [axi_id_bits-1:0] id, input logic full);
        int idx;
        awid = id;
        awaddr.raw = addr;
        awlen = len;
        awburst = burst_incr;
        awvalid = 1'b1;
        wait_for(ch_aw, "awready");
        to_drive_point();
        awvalid = 1'b0;
        for (int b = 0; b <= len; b++) begin
            wdata = $random(seed);
            wstrb = full ? '1 : 4'($random(seed));
            wlast = b == len;
            wvalid = 1'b1;
            wait_for(ch_w, "wready");
            idx = word_index(addr, b);
            for (int k = 0; k < axi_strb_bits; k++) begin
                if (wstrb[k]) begin
                    model[idx][8*k +: 8] = wdata[8*k +: 8];
                end
            end
            to_drive_point();
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        bready = 1'b1;
        wait_for(ch_b, "bvalid");
        check_resp("bresp", resp_okay, bresp);
        check_id("bid", id, bid);
        to_drive_point();
        bready = 1'b0;
    endtask

    task automatic read_burst(input logic [axi_addr_bits-1:0] addr,
                              input logic [axi_len_bits-1:0] len,
                              input logic [axi_id_bits-1:0] id, input logic stall);
        stall_on = stall;
        rready = 1'b1;
        arid = id;
        araddr.raw = addr;
        arlen = len;
        arburst = burst_incr;
        arvalid = 1'b1;
        wait_for(ch_ar, "arready");
        to_drive_point();
        arvalid = 1'b0;
        for (int b = 0; b <= len; b++) begin
            wait_for(ch_r, "an R beat");
            check_rdata("rdata", model[word_index(addr, b)], rdata);
            check_resp("rresp", resp_okay, rresp);
            check_id("rid", id, rid);
            check_last("rlast", b == len, rlast);
            to_drive_point();
            rready = stall_on ? 1'($random(seed)) : 1'b1;
        end
        // anything still valid here would be a repeated beat
        @(negedge clk);
        if (rvalid) begin
            $display("R beat still valid after rlast in %s", test_name);
            stop_with_failure();
        end
        to_drive_point();
    endtask

    initial begin
        logic [axi_addr_bits-1:0] addr;
        logic [axi_addr_bits-1:0] alias_addr;
        logic [axi_len_bits-1:0]  len;
        logic [axi_id_bits-1:0]   id;
        int                       ar_before;
        seed = 9;
        stall_on = 1'b0;
        test_name = "reset";
        rst = 1'b0;
        {awid, awaddr, awlen, awburst, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arburst, arvalid, rready} = '0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b1;

        // every word known before the first read
        test_name = "fill";
        for (int i = 0; i < depth / 16; i++) begin
            write_burst(i * 64, 4'd15, axi_id_bits'(i), 1'b1);
        end

        // single full words first, then bursts with random strobes
        for (int i = 0; i < 50; i++) begin
            test_name = (i < 20) ? "single_beat" : "incr_burst";
            addr = low_addr();
            len = (i < 20) ? '0 : axi_len_bits'($random(seed));
            write_burst(addr, len, axi_id_bits'($random(seed)), i < 20);
            read_burst(addr, len, axi_id_bits'($random(seed)), 1'b0);
        end

        test_name = "rready_stall";
        for (int i = 0; i < 20; i++) begin
            addr = low_addr();
            len = axi_len_bits'($random(seed));
            read_burst(addr, len, axi_id_bits'($random(seed)), 1'b1);
        end

        // AR parked behind the write has to see the new data
        test_name = "aw_ar_same_cycle";
        for (int i = 0; i < 5; i++) begin
            addr = low_addr();
            len = axi_len_bits'($random(seed));
            id = axi_id_bits'($random(seed));
            arid = ~id;
            araddr.raw = addr;
            arlen = len;
            arburst = burst_incr;
            arvalid = 1'b1;
            ar_before = ar_accepts;
            write_burst(addr, len, id, 1'b0);
            if (ar_accepts != ar_before) begin
                $display("AR accepted ahead of the pending write in %s", test_name);
                stop_with_failure();
            end
            read_burst(addr, len, ~id, 1'b0);
        end

        test_name = "address_alias";
        for (int i = 0; i < 10; i++) begin
            addr = low_addr();
            alias_addr = $random(seed);
            // same word index, one bit set above the array
            alias_addr[a_bits+1:0] = addr[a_bits+1:0];
            alias_addr[a_bits+2] = 1'b1;
            len = axi_len_bits'($random(seed));
            write_burst(alias_addr, len, axi_id_bits'(i), 1'b1);
            read_burst(addr, len, axi_id_bits'(i), 1'b1);
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2) clk_o = ~clk_o;
        end
    end

endmodule
